// ==== tb.f ====
logic/nocPkg.sv
logic/flitFifo.sv
logic/grantTimer.sv
logic/portArbiter.sv
logic/outputLink.sv
logic/routerOutputPort.sv
testbench/routerOutputPortTb.sv

// ==== Bender.yml ====
package:
  name: router_output_port

sources:
  - logic/nocPkg.sv
  - logic/flitFifo.sv
  - logic/grantTimer.sv
  - logic/portArbiter.sv
  - logic/outputLink.sv
  - logic/routerOutputPort.sv
  - target: test
    files:
      - testbench/routerOutputPortTb.sv

// ==== testbench/routerOutputPortTb.sv ====
`timescale 1ns/1ps

module routerOutputPortTb;

  localparam int totalFlits = 4 + 5 * 2 * 4 + 2 * 6 + 8;
  localparam int cycleLimit = 10 * totalFlits + 200;

  logic clk = 1'b0;
  logic rst = 1'b1;
  nocPkg::portMask inCyc = '0;
  nocPkg::portMask inStb = '0;
  nocPkg::portMask inAck;
  nocPkg::flitWord inDat [nocPkg::numPorts];
  logic outCyc;
  logic outStb;
  nocPkg::linkWord outDat;
  logic outAck = 1'b0;
  nocPkg::portMask grant;

  nocPkg::flitWord expQ [nocPkg::numPorts][$];  // Accepted flits per source
  int maxLen [nocPkg::numPorts];  // Longest header in the current phase
  int seed = 22206;
  int ackMode = 0;  // 0 stalled, 1 always, 2 random
  int cycles = 0;
  int resetErrors = 0;
  int dataErrors = 0;
  int arbErrors = 0;
  int flowErrors = 0;
  logic rstPrev = 1'b0;
  int rstEdges = 0;
  nocPkg::portMask prevGrant = '0;
  nocPkg::portMask prevReq = '0;
  logic havePrev = 1'b0;
  int holdLen = 0;
  logic stalling = 1'b0;
  int stallAcks = 0;

  always #10 clk = ~clk;

  routerOutputPort routerOutputPort_inst (
    .clk    (clk),
    .rst    (rst),
    .inCyc  (inCyc),
    .inStb  (inStb),
    .inAck  (inAck),
    .inDat  (inDat),
    .outCyc (outCyc),
    .outStb (outStb),
    .outDat (outDat),
    .outAck (outAck),
    .grant  (grant)
  );

  // ########################################
  // Stimulus helpers
  // ########################################
  task automatic writeFlit(input int p, input nocPkg::flitWord f);
    inCyc[p] = 1'b1;
    inStb[p] = 1'b1;
    inDat[p] = f;
    do
      @(negedge clk);
    while (!inAck[p]);
    expQ[p].push_back(f);
    if (f.hdr.kind == nocPkg::flitHead && f.hdr.length > maxLen[p])
      maxLen[p] = f.hdr.length;
  endtask

  task automatic sendPacket(input int p, input int len, input int nBody);
    nocPkg::flitWord f;
    f.hdr.kind = nocPkg::flitHead;
    f.hdr.length = 12'(len);
    f.hdr.dest = 16'(p * 256 + len);
    writeFlit(p, f);
    for (int i = 0; i <= nBody; i++)
    begin
      f.body.kind = (i == nBody) ? nocPkg::flitTail : nocPkg::flitBody;
      f.body.spare = '0;
      f.body.payload = 16'(p * 4096 + len * 64 + i);
      writeFlit(p, f);
    end
    inCyc[p] = 1'b0;
    inStb[p] = 1'b0;
  endtask

  task automatic sendPair(input int p, input int lenA, input int lenB);
    sendPacket(p, lenA, 2);
    sendPacket(p, lenB, 2);
  endtask

  task automatic clearLengths();
    for (int p = 0; p < nocPkg::numPorts; p++)
      maxLen[p] = 0;
  endtask

  task automatic waitDrain();
    int pending;
    do
    begin
      @(negedge clk);
      pending = outStb;
      for (int p = 0; p < nocPkg::numPorts; p++)
        pending += expQ[p].size();
    end
    while (pending != 0);
  endtask

  task automatic reportCounts();
    $display("Errors: reset %0d, data %0d, arbiter %0d, flow %0d",
             resetErrors, dataErrors, arbErrors, flowErrors);
  endtask

  // Rotation after the holder or base order from idle
  function automatic nocPkg::portMask nextGrant(input nocPkg::portMask held,
                                                input nocPkg::portMask req);
    int start;
    int span;
    int idx;
    start = 0;
    span = nocPkg::numPorts;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (held[i])
      begin
        start = i + 1;
        span = nocPkg::numPorts - 1;
      end
    end
    for (int k = 0; k < span; k++)
    begin
      idx = (start + k) % nocPkg::numPorts;
      if (req[idx])
        return nocPkg::portMask'(1 << idx);
    end
    return '0;
  endfunction

  always @(negedge clk)
  begin
    int r;
    r = $random(seed);
    outAck = outStb && (ackMode == 1 || (ackMode == 2 && r[0]));
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycleLimit)
    begin
      $display("Timeout after %0d cycles, the output did not drain", cycles);
      reportCounts();
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ########################################
  // Checks
  // ########################################
  always @(posedge clk)
  begin
    nocPkg::portMask req;
    nocPkg::flitWord expFlit;
    logic known;
    int cur;
    req = routerOutputPort_inst.notEmpty;
    if ((rst && rstEdges > 0) || (!rst && rstPrev))
      assert ({outCyc, outStb, inAck, grant} == '0)
      else
      begin
        $display("ERROR reset outCyc %h outStb %h inAck %h grant %h, expected 0",
                 outCyc, outStb, inAck, grant);
        resetErrors++;
      end
    if (outStb && outAck)
    begin
      known = outDat.srcPort < nocPkg::numPorts && expQ[outDat.srcPort].size() > 0;
      assert (known)
      else
      begin
        $display("Output word tagged port %0d was never accepted", outDat.srcPort);
        dataErrors++;
      end
      if (known)
      begin
        expFlit = expQ[outDat.srcPort].pop_front();
        assert (outDat.flit == expFlit)
        else
        begin
          $display("ERROR outDat.flit port %0d expected %h got %h",
                   outDat.srcPort, expFlit, outDat.flit);
          dataErrors++;
        end
      end
    end
    if (rst)
    begin
      havePrev = 1'b0;
      prevGrant = '0;
      holdLen = 0;
    end
    else
    begin
      if (havePrev && (prevGrant == '0 || grant != prevGrant))
        assert (grant == nextGrant(prevGrant, prevReq))
        else
        begin
          $display("ERROR grant expected %h got %h", nextGrant(prevGrant, prevReq), grant);
          arbErrors++;
        end
      holdLen = (grant != '0 && grant == prevGrant) ? holdLen + 1 : int'(grant != '0);
      cur = 0;
      for (int i = 0; i < nocPkg::numPorts; i++)
        if (grant[i])
          cur = i;
      assert (holdLen <= maxLen[cur] + 1)
      else
      begin
        $display("Grant to port %0d held %0d cycles, longer than its timeout", cur, holdLen);
        arbErrors++;
      end
      prevGrant = grant;
      prevReq = req;
      havePrev = 1'b1;
    end
    if (stalling && inAck[nocPkg::portL])
      stallAcks++;
    assert (stallAcks <= nocPkg::fifoDepth + 1)  // Buffer plus holding register
    else
    begin
      $display("Port L accepted %0d flits while the output was stalled", stallAcks);
      flowErrors++;
    end
    rstPrev = rst;
    if (rst)
      rstEdges++;
  end

  holdStable: assert property (@(posedge clk) disable iff (rst)
    outStb && !outAck |=> outCyc && outStb && $stable(outDat))
  else
  begin
    $display("Output word changed or dropped before its ack");
    flowErrors++;
  end

  initial
  begin
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      inDat[p] = '0;
      maxLen[p] = 0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    ackMode = 1;  // One North packet with a free output
    sendPacket(nocPkg::portN, 3, 2);
    waitDrain();

    clearLengths();
    ackMode = 2;
    fork
      sendPair(0, 2, 5);
      sendPair(1, 3, 6);
      sendPair(2, 4, 2);
      sendPair(3, 5, 3);
      sendPair(4, 6, 4);
    join
    waitDrain();

    // Two requesters trade grants on timeout while the output stalls
    clearLengths();
    ackMode = 0;
    fork
      sendPacket(nocPkg::portE, 3, 4);
      sendPacket(nocPkg::portW, 5, 4);
      begin
        repeat (40) @(posedge clk);
        ackMode = 2;
      end
    join
    waitDrain();

    clearLengths();
    stallAcks = 0;
    stalling = 1'b1;
    ackMode = 0;
    fork
      sendPacket(nocPkg::portL, 2, 6);
      begin
        repeat (40) @(negedge clk);
        stalling = 1'b0;
        @(posedge clk);
        ackMode = 1;
      end
    join
    waitDrain();

    repeat (5) @(negedge clk);
    reportCounts();
    if (resetErrors + dataErrors + arbErrors + flowErrors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== logic/routerOutputPort.sv ====
`timescale 1ns/1ps

module routerOutputPort (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::portMask inCyc,
  input  nocPkg::portMask inStb,
  output nocPkg::portMask inAck,
  input  nocPkg::flitWord inDat [nocPkg::numPorts],
  output logic            outCyc,
  output logic            outStb,
  output nocPkg::linkWord outDat,
  input  logic            outAck,
  output nocPkg::portMask grant
);

  nocPkg::flitWord heads [nocPkg::numPorts];
  nocPkg::portMask notEmpty;
  nocPkg::portMask pop;

  // ########################################
  // Input buffers
  // ########################################
  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genInput
    flitFifo flitFifo_inst (
      .clk      (clk),
      .rst      (rst),
      .inCyc    (inCyc[i]),
      .inStb    (inStb[i]),
      .inDat    (inDat[i]),
      .inAck    (inAck[i]),
      .pop      (pop[i]),
      .head     (heads[i]),
      .notEmpty (notEmpty[i])
    );
  end

  portArbiter portArbiter_inst (
    .clk   (clk),
    .rst   (rst),
    .req   (notEmpty),  // Any buffered flit asks for the link
    .heads (heads),
    .grant (grant)
  );

  outputLink outputLink_inst (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .heads    (heads),
    .notEmpty (notEmpty),
    .pop      (pop),
    .outCyc   (outCyc),
    .outStb   (outStb),
    .outDat   (outDat),
    .outAck   (outAck)
  );

endmodule

// ==== logic/outputLink.sv ====
`timescale 1ns/1ps

module outputLink (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::portMask grant,
  input  nocPkg::flitWord heads [nocPkg::numPorts],
  input  nocPkg::portMask notEmpty,
  output nocPkg::portMask pop,
  output logic            outCyc,
  output logic            outStb,
  output nocPkg::linkWord outDat,
  input  logic            outAck
);

  nocPkg::flitWord selHead;
  logic [2:0] selPort;
  logic selValid;
  logic load;

  // Granted head, grant is one-hot
  always_comb
  begin
    selHead = '0;
    selPort = '0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i])
      begin
        selHead = heads[i];
        selPort = 3'(i);
      end
    end
  end

  assign selValid = |(grant & notEmpty);
  assign load = selValid && (!outStb || outAck);  // Empty or being acked
  assign pop = load ? (grant & notEmpty) : '0;
  assign outCyc = outStb;

  // ########################################
  // Wishbone master holding register
  // ########################################
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      outDat.srcPort <= selPort;
      outDat.flit <= selHead;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outStb <= 1'b0;
    else if (load)
      outStb <= 1'b1;
    else if (outAck)
      outStb <= 1'b0;  // Nothing new to send
  end

endmodule

// ==== logic/portArbiter.sv ====
`timescale 1ns/1ps

module portArbiter (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::portMask req,
  input  nocPkg::flitWord heads [nocPkg::numPorts],
  output nocPkg::portMask grant
);

  nocPkg::arbState state;
  nocPkg::arbState nextState;
  nocPkg::portMask run;
  nocPkg::portMask timesUp;

  // First requester in span ports from start, wrapping around
  function automatic nocPkg::arbState firstReq(
    input nocPkg::portMask r,
    input int start,
    input int span
  );
    int idx;
    logic found;
    found = 1'b0;
    firstReq = nocPkg::idle;
    for (int k = 0; k < span; k++)
    begin
      idx = (start + k) % nocPkg::numPorts;
      if (!found && r[idx])
      begin
        firstReq = nocPkg::arbState'(6'b000010 << idx);
        found = 1'b1;
      end
    end
  endfunction

  // ########################################
  // Per-port timeout
  // ########################################
  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genTimer
    grantTimer grantTimer_inst (
      .clk       (clk),
      .rst       (rst),
      .head      (heads[i]),
      .headValid (req[i]),
      .run       (run[i]),
      .timesUp   (timesUp[i])
    );
  end

  // ########################################
  // Grant FSM
  // ########################################
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::idle;
    else
      state <= nextState;
  end

  assign grant = state[nocPkg::numPorts:1];  // Zero in idle

  always_comb
  begin
    int cur;
    cur = 0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i])
        cur = i;
    end
    run = '0;
    nextState = state;
    if (state == nocPkg::idle)
      nextState = firstReq(req, nocPkg::portL, nocPkg::numPorts);
    else if (req[cur] && !timesUp[cur])
    begin
      run[cur] = 1'b1;  // Hold and keep counting
      nextState = state;
    end
    else
    begin
      // Rotate past the current holder, idle if nobody asks
      nextState = firstReq(req, cur + 1, nocPkg::numPorts - 1);
    end
  end

endmodule

// ==== logic/grantTimer.sv ====
`timescale 1ns/1ps

module grantTimer (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::flitWord head,
  input  logic            headValid,
  input  logic            run,
  output logic            timesUp
);

  logic [nocPkg::lenWidth-1:0] limit;
  logic [nocPkg::lenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Latest header at the FIFO head sets the limit
      if (headValid && head.hdr.kind == nocPkg::flitHead)
        limit <= head.hdr.length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count >= limit);  // Also covers a shorter new limit

endmodule

// ==== logic/flitFifo.sv ====
`timescale 1ns/1ps

module flitFifo (
  input  logic            clk,
  input  logic            rst,
  input  logic            inCyc,
  input  logic            inStb,
  input  nocPkg::flitWord inDat,
  output logic            inAck,
  input  logic            pop,
  output nocPkg::flitWord head,
  output logic            notEmpty
);

  nocPkg::flitWord mem [nocPkg::fifoDepth];

  logic [$clog2(nocPkg::fifoDepth)-1:0]   wrPtr;
  logic [$clog2(nocPkg::fifoDepth)-1:0]   rdPtr;
  logic [$clog2(nocPkg::fifoDepth+1)-1:0] count;
  logic full;
  logic push;
  logic doPop;

  assign full = (count == nocPkg::fifoDepth);
  assign push = inCyc && inStb && !full && !inAck;  // Slave accepts once per strobe
  assign doPop = pop && notEmpty;
  assign notEmpty = (count != 0);
  assign head = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inDat;
  end

  // ########################################
  // Pointers, count and ack
  // ########################################
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      inAck <= 1'b0;
    end
    else
    begin
      inAck <= push;  // One cycle wide
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({push, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/nocPkg.sv ====
package nocPkg;

  // ########################################
  // Ports and widths
  // ########################################
  localparam int numPorts = 5;

  // Base priority order
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  localparam int idWidth = 3;
  localparam int lenWidth = 12;
  localparam int payloadWidth = 16;
  localparam int fifoDepth = 4;

  // Flit kinds, one-hot
  localparam logic [idWidth-1:0] flitHead = 3'b001;
  localparam logic [idWidth-1:0] flitBody = 3'b010;
  localparam logic [idWidth-1:0] flitTail = 3'b100;

  typedef logic [numPorts-1:0] portMask;

  // ########################################
  // Flit formats
  // ########################################
  typedef struct packed {
    logic [idWidth-1:0]      kind;
    logic [lenWidth-1:0]     length;  // Grant timeout in cycles
    logic [payloadWidth-1:0] dest;
  } headerFlit;

  typedef struct packed {
    logic [idWidth-1:0]      kind;
    logic [lenWidth-1:0]     spare;
    logic [payloadWidth-1:0] payload;
  } bodyFlit;

  // Same word, read by its kind field
  typedef union packed {
    headerFlit hdr;
    bodyFlit   body;
  } flitWord;

  // Arbiter states, one-hot
  typedef enum logic [5:0] {
    idle   = 6'b000001,
    grantL = 6'(2 << portL),
    grantN = 6'(2 << portN),
    grantE = 6'(2 << portE),
    grantW = 6'(2 << portW),
    grantS = 6'(2 << portS)
  } arbState;

  // Output link word
  typedef struct packed {
    logic [2:0] srcPort;
    flitWord    flit;
  } linkWord;

endpackage
